// File: rtl/uno_pkg.sv
package uno_pkg;

    // card fields: color in [5:4], rank in [3:0]
    typedef logic [5:0]  card_t;
    typedef logic [1:0]  color_t;
    typedef logic [3:0]  rank_t;
    typedef logic [5:0]  points_t;
    typedef logic [10:0] score_t;
    typedef logic [4:0]  pile_cnt_t;
    typedef logic [2:0]  wild_cnt_t;
    typedef logic [6:0]  hand_cnt_t;

    typedef struct packed {
        logic  pass;   // draw one card instead of playing
        card_t card;
    } play_req_t;

    typedef struct packed {
        logic    number;
        logic    action;
        logic    wild;
        logic    wild4;
        points_t points;
    } card_class_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_DRAW,
        ST_PLAY,
        ST_SEARCH,
        ST_CHOOSE,
        ST_OUT,
        ST_PASS_DRAW
    } turn_state_t;

    localparam rank_t   RANK_WILD         = 4'd13;
    localparam rank_t   RANK_WILD4        = 4'd14;
    localparam rank_t   RANK_FIRST_ACTION = 4'd10;  // skip, reverse, draw two

    localparam points_t ACTION_POINTS = 6'd20;
    localparam points_t WILD_POINTS   = 6'd50;

    localparam int      DEAL_COUNT = 7;

    localparam card_t   EMPTY_CARD = '1;

endpackage

// File: rtl/card_decode.sv
`timescale 1ns/1ps

module card_decode
    import uno_pkg::*;
(
    input  card_t       i_card,
    input  card_t       i_top_card,
    output card_class_t o_class,
    output logic        o_legal
);

    rank_t   rank;
    color_t  color;
    rank_t   top_rank;
    color_t  top_color;
    logic    is_number;
    logic    is_action;
    logic    is_wild;
    logic    is_wild4;
    points_t points;

    assign rank      = i_card[3:0];
    assign color     = i_card[5:4];
    assign top_rank  = i_top_card[3:0];
    assign top_color = i_top_card[5:4];

    assign is_number = (rank < RANK_FIRST_ACTION);
    assign is_action = (rank >= RANK_FIRST_ACTION) && (rank < RANK_WILD);
    assign is_wild   = (rank == RANK_WILD);
    assign is_wild4  = (rank == RANK_WILD4);

    always_comb begin
        if (is_number) begin
            points = points_t'(rank);
        end else if (is_action) begin
            points = ACTION_POINTS;
        end else if (is_wild || is_wild4) begin
            points = WILD_POINTS;
        end else begin
            points = '0;  // empty slot pattern
        end
    end

    assign o_class.number = is_number;
    assign o_class.action = is_action;
    assign o_class.wild   = is_wild;
    assign o_class.wild4  = is_wild4;
    assign o_class.points = points;

    // wilds go on anything, a chosen color shows up in the top card
    assign o_legal = is_wild || is_wild4 || (color == top_color) || (rank == top_rank);

endmodule

// File: rtl/color_pile.sv
`timescale 1ns/1ps

module color_pile
    import uno_pkg::*;
#(
    parameter int PILE_DEPTH = 25
) (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_append,
    input  logic      i_find,
    input  card_t     i_card,
    output logic      o_found,
    output logic      o_miss,
    output pile_cnt_t o_count
);

    card_t     slots [PILE_DEPTH];
    pile_cnt_t count;
    pile_cnt_t scan_idx;
    rank_t     target_rank;
    card_t     scan_card;
    logic      scanning;
    logic      at_end;
    logic      hit;
    logic      full;
    logic      do_append;

    assign full      = (count == pile_cnt_t'(PILE_DEPTH));
    assign do_append = i_append && !full;  // full pile drops the card
    assign at_end    = (scan_idx == count);

    // slots past count hold EMPTY_CARD
    assign scan_card = at_end ? EMPTY_CARD : slots[scan_idx];
    assign hit       = scanning && !at_end && (scan_card[3:0] == target_rank);

    assign o_found = hit;
    assign o_miss  = scanning && at_end;
    assign o_count = count;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count    <= '0;
            scanning <= 1'b0;
            scan_idx <= '0;
        end else begin
            if (i_find) begin
                scanning <= 1'b1;
                scan_idx <= '0;
            end else if (scanning) begin
                if (at_end || hit) begin
                    scanning <= 1'b0;
                end else begin
                    scan_idx <= scan_idx + 1'b1;  // one entry per cycle
                end
            end

            if (hit) begin
                count <= count - 1'b1;
            end else if (do_append) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < PILE_DEPTH; i++) begin
                slots[i] <= EMPTY_CARD;
            end
        end else if (hit) begin
            // close the gap, keep arrival order
            for (int i = 0; i < PILE_DEPTH - 1; i++) begin
                if (pile_cnt_t'(i) >= scan_idx) begin
                    slots[i] <= slots[i + 1];
                end
            end
            slots[PILE_DEPTH - 1] <= EMPTY_CARD;
        end else if (do_append) begin
            slots[count] <= i_card;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_find) begin
            target_rank <= i_card[3:0];
        end
    end

endmodule

// File: rtl/turn_control.sv
`timescale 1ns/1ps

module turn_control
    import uno_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_init,
    input  logic        i_start,
    input  logic        i_draw_two,
    input  logic        i_draw_four,
    input  logic        i_card_valid,
    output logic        o_card_ready,
    input  logic        i_play_valid,
    input  play_req_t   i_play,
    output logic        o_play_ready,
    input  logic        i_color_valid,
    input  color_t      i_color,
    output logic        o_color_ready,
    output logic        o_out_valid,
    output card_t       o_out_card,
    input  logic        i_out_ready,
    output logic        o_play_reject,
    output logic        o_turn_done,
    input  card_class_t i_req_class,
    input  logic        i_req_legal,
    input  card_class_t i_draw_class,
    input  logic        i_found,
    input  logic        i_miss,
    input  logic        i_has_wild,
    input  logic        i_has_wild4,
    output logic        o_append,
    output logic        o_find,
    output logic        o_add,
    output logic        o_remove,
    output card_class_t o_tally_class
);

    turn_state_t state;
    turn_state_t state_d;
    logic [2:0]  draw_left;
    logic [2:0]  draw_left_d;
    logic        to_play;
    logic        to_play_d;
    logic        reject_d;
    logic        done_d;
    card_t       req_card;
    card_class_t req_class;
    logic        card_xfer;
    logic        play_xfer;
    logic        color_xfer;
    logic        req_wild;
    logic        wild_held;
    logic        draw_wild;

    assign o_card_ready  = (state == ST_DRAW) || (state == ST_PASS_DRAW);
    assign o_play_ready  = (state == ST_PLAY);
    assign o_color_ready = (state == ST_CHOOSE);
    assign o_out_valid   = (state == ST_OUT);

    assign card_xfer  = i_card_valid && o_card_ready;
    assign play_xfer  = i_play_valid && o_play_ready;
    assign color_xfer = i_color_valid && o_color_ready;

    assign req_wild  = i_req_class.wild || i_req_class.wild4;
    assign wild_held = (i_req_class.wild && i_has_wild) || (i_req_class.wild4 && i_has_wild4);
    assign draw_wild = i_draw_class.wild || i_draw_class.wild4;

    assign o_add    = card_xfer;
    assign o_append = card_xfer && !draw_wild;  // wilds are only counted
    assign o_find   = play_xfer && !i_play.pass && i_req_legal && !req_wild;
    assign o_remove = ((state == ST_SEARCH) && i_found) || color_xfer;

    assign o_tally_class = o_card_ready ? i_draw_class : req_class;

    always_comb begin
        state_d     = state;
        draw_left_d = draw_left;
        to_play_d   = to_play;
        reject_d    = 1'b0;
        done_d      = 1'b0;
        case (state)
            ST_IDLE: begin
                if (i_start) begin
                    if (i_draw_two || i_draw_four) begin
                        state_d     = ST_DRAW;
                        draw_left_d = i_draw_four ? 3'd4 : 3'd2;
                        to_play_d   = 1'b1;  // penalty, then play
                    end else begin
                        state_d = ST_PLAY;
                    end
                end else if (i_init) begin
                    state_d     = ST_DRAW;
                    draw_left_d = 3'(DEAL_COUNT);
                    to_play_d   = 1'b0;
                end
            end
            ST_DRAW: begin
                if (card_xfer) begin
                    if (draw_left == 3'd1) begin
                        state_d = to_play ? ST_PLAY : ST_IDLE;
                        done_d  = !to_play;
                    end
                    draw_left_d = draw_left - 1'b1;
                end
            end
            ST_PLAY: begin
                if (play_xfer) begin
                    if (i_play.pass) begin
                        state_d = ST_PASS_DRAW;
                    end else if (!i_req_legal) begin
                        reject_d = 1'b1;
                    end else if (req_wild) begin
                        if (wild_held) begin
                            state_d = ST_CHOOSE;
                        end else begin
                            reject_d = 1'b1;
                        end
                    end else begin
                        state_d = ST_SEARCH;
                    end
                end
            end
            ST_SEARCH: begin
                if (i_found) begin
                    state_d = ST_OUT;
                end else if (i_miss) begin
                    state_d  = ST_PLAY;  // not held, may ask again
                    reject_d = 1'b1;
                end
            end
            ST_CHOOSE: begin
                if (color_xfer) begin
                    state_d = ST_OUT;
                end
            end
            ST_OUT: begin
                if (i_out_ready) begin
                    state_d = ST_IDLE;
                    done_d  = 1'b1;
                end
            end
            ST_PASS_DRAW: begin
                if (card_xfer) begin
                    state_d = ST_IDLE;
                    done_d  = 1'b1;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= ST_IDLE;
            draw_left     <= '0;
            to_play       <= 1'b0;
            o_play_reject <= 1'b0;
            o_turn_done   <= 1'b0;
        end else begin
            state         <= state_d;
            draw_left     <= draw_left_d;
            to_play       <= to_play_d;
            o_play_reject <= reject_d;
            o_turn_done   <= done_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (play_xfer) begin
            req_card  <= i_play.card;
            req_class <= i_req_class;
        end
        if ((state == ST_SEARCH) && i_found) begin
            o_out_card <= req_card;
        end else if (color_xfer) begin
            o_out_card <= {i_color, req_card[3:0]};  // chosen color, wild rank
        end
    end

endmodule

// File: rtl/hand_tally.sv
`timescale 1ns/1ps

module hand_tally
    import uno_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_add,
    input  logic        i_remove,
    input  card_class_t i_class,
    input  hand_cnt_t   i_pile_total,
    output logic        o_has_wild,
    output logic        o_has_wild4,
    output hand_cnt_t   o_hand_num,
    output score_t      o_score
);

    wild_cnt_t wild_cnt;
    wild_cnt_t wild4_cnt;
    wild_cnt_t wild_cnt_d;
    wild_cnt_t wild4_cnt_d;
    score_t    score_d;
    hand_cnt_t hand_d;
    logic      is_wild;
    logic      pile_add;
    logic      pile_sub;

    assign is_wild  = i_class.wild || i_class.wild4;
    assign pile_add = i_add && !is_wild;
    assign pile_sub = i_remove && !is_wild;

    always_comb begin
        wild_cnt_d  = wild_cnt;
        wild4_cnt_d = wild4_cnt;
        score_d     = o_score;
        if (i_add) begin
            wild_cnt_d  = wild_cnt + wild_cnt_t'(i_class.wild);
            wild4_cnt_d = wild4_cnt + wild_cnt_t'(i_class.wild4);
            score_d     = o_score + score_t'(i_class.points);
        end else if (i_remove) begin
            wild_cnt_d  = wild_cnt - wild_cnt_t'(i_class.wild);
            wild4_cnt_d = wild4_cnt - wild_cnt_t'(i_class.wild4);
            score_d     = o_score - score_t'(i_class.points);
        end
        // pile counts move on this same edge
        hand_d = i_pile_total + hand_cnt_t'(pile_add) - hand_cnt_t'(pile_sub);
        hand_d = hand_d + hand_cnt_t'(wild_cnt_d) + hand_cnt_t'(wild4_cnt_d);
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wild_cnt   <= '0;
            wild4_cnt  <= '0;
            o_score    <= '0;
            o_hand_num <= '0;
        end else begin
            wild_cnt   <= wild_cnt_d;
            wild4_cnt  <= wild4_cnt_d;
            o_score    <= score_d;
            o_hand_num <= hand_d;
        end
    end

    assign o_has_wild  = (wild_cnt != '0);
    assign o_has_wild4 = (wild4_cnt != '0);

endmodule

// File: rtl/uno_player.sv
`timescale 1ns/1ps

module uno_player
    import uno_pkg::*;
#(
    parameter int PILE_DEPTH = 25
) (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_init,
    input  logic      i_start,
    input  logic      i_draw_two,
    input  logic      i_draw_four,
    input  card_t     i_top_card,
    input  logic      i_card_valid,
    input  card_t     i_card,
    output logic      o_card_ready,
    input  logic      i_play_valid,
    input  play_req_t i_play,
    output logic      o_play_ready,
    input  logic      i_color_valid,
    input  color_t    i_color,
    output logic      o_color_ready,
    output logic      o_out_valid,
    output card_t     o_out_card,
    input  logic      i_out_ready,
    output logic      o_play_reject,
    output logic      o_turn_done,
    output hand_cnt_t o_hand_num,
    output score_t    o_score
);

    card_class_t draw_class;
    card_class_t req_class;
    card_class_t tally_class;
    logic        req_legal;
    logic        append;
    logic        find;
    logic        add;
    logic        remove;
    logic        has_wild;
    logic        has_wild4;
    card_t       pile_card;
    color_t      pile_sel;
    logic [3:0]  pile_found;
    logic [3:0]  pile_miss;
    pile_cnt_t   pile_count [4];
    hand_cnt_t   pile_total;

    card_decode u_draw_decode (
        .i_card     (i_card),
        .i_top_card (i_top_card),
        .o_class    (draw_class),
        .o_legal    ()
    );

    card_decode u_req_decode (
        .i_card     (i_play.card),
        .i_top_card (i_top_card),
        .o_class    (req_class),
        .o_legal    (req_legal)
    );

    // appends only while drawing, finds only in play
    assign pile_card = o_card_ready ? i_card : i_play.card;
    assign pile_sel  = pile_card[5:4];

    for (genvar c = 0; c < 4; c++) begin : g_pile
        color_pile #(
            .PILE_DEPTH (PILE_DEPTH)
        ) u_pile (
            .i_clk    (i_clk),
            .i_rst_n  (i_rst_n),
            .i_append (append && (pile_sel == color_t'(c))),
            .i_find   (find && (pile_sel == color_t'(c))),
            .i_card   (pile_card),
            .o_found  (pile_found[c]),
            .o_miss   (pile_miss[c]),
            .o_count  (pile_count[c])
        );
    end

    assign pile_total = hand_cnt_t'(pile_count[0]) + hand_cnt_t'(pile_count[1])
                      + hand_cnt_t'(pile_count[2]) + hand_cnt_t'(pile_count[3]);

    turn_control u_turn_control (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_init        (i_init),
        .i_start       (i_start),
        .i_draw_two    (i_draw_two),
        .i_draw_four   (i_draw_four),
        .i_card_valid  (i_card_valid),
        .o_card_ready  (o_card_ready),
        .i_play_valid  (i_play_valid),
        .i_play        (i_play),
        .o_play_ready  (o_play_ready),
        .i_color_valid (i_color_valid),
        .i_color       (i_color),
        .o_color_ready (o_color_ready),
        .o_out_valid   (o_out_valid),
        .o_out_card    (o_out_card),
        .i_out_ready   (i_out_ready),
        .o_play_reject (o_play_reject),
        .o_turn_done   (o_turn_done),
        .i_req_class   (req_class),
        .i_req_legal   (req_legal),
        .i_draw_class  (draw_class),
        .i_found       (|pile_found),  // one pile scans at a time
        .i_miss        (|pile_miss),
        .i_has_wild    (has_wild),
        .i_has_wild4   (has_wild4),
        .o_append      (append),
        .o_find        (find),
        .o_add         (add),
        .o_remove      (remove),
        .o_tally_class (tally_class)
    );

    hand_tally u_hand_tally (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_add        (add),
        .i_remove     (remove),
        .i_class      (tally_class),
        .i_pile_total (pile_total),
        .o_has_wild   (has_wild),
        .o_has_wild4  (has_wild4),
        .o_hand_num   (o_hand_num),
        .o_score      (o_score)
    );

endmodule

// File: sim/uno_player_assertions.sv
`timescale 1ns/1ps

module uno_player_assertions
    import uno_pkg::*;
#(
    parameter int PILE_DEPTH = 25
) (
    input logic      i_clk,
    input logic      i_rst_n,
    input logic      i_card_ready,
    input logic      i_play_ready,
    input logic      i_color_ready,
    input logic      i_out_valid,
    input card_t     i_out_card,
    input logic      i_out_ready,
    input logic      i_play_reject,
    input logic      i_turn_done,
    input logic      i_append,
    input color_t    i_pile_sel,
    input pile_cnt_t i_pile_count [4]
);

    a_out_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out_card))
        else $error("out channel changed while stalled");

    // first edge after reset release sees the reset values
    a_reset_quiet: assert property (@(posedge i_clk)
        $rose(i_rst_n) |-> !i_card_ready && !i_play_ready && !i_color_ready && !i_out_valid)
        else $error("ready or valid high after reset");

    a_single_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_play_reject && i_turn_done))
        else $error("reject and turn end pulsed together");

    for (genvar c = 0; c < 4; c++) begin : g_full
        a_full_append: assert property (@(posedge i_clk) disable iff (!i_rst_n)
            i_append && (i_pile_sel == color_t'(c)) |-> i_pile_count[c] != pile_cnt_t'(PILE_DEPTH))
            else $error("append to full pile %0d", c);
    end

endmodule

bind uno_player uno_player_assertions #(
    .PILE_DEPTH (PILE_DEPTH)
) u_assertions (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_card_ready  (o_card_ready),
    .i_play_ready  (o_play_ready),
    .i_color_ready (o_color_ready),
    .i_out_valid   (o_out_valid),
    .i_out_card    (o_out_card),
    .i_out_ready   (i_out_ready),
    .i_play_reject (o_play_reject),
    .i_turn_done   (o_turn_done),
    .i_append      (append),
    .i_pile_sel    (pile_sel),
    .i_pile_count  (pile_count)
);

// File: sim/tb_uno_player.sv
`timescale 1ns/1ps

module tb_uno_player
    import uno_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int N_STEPS    = 32;  // turns and requests over all tests

    logic        clk = 1'b0;
    logic        rst_n;
    logic        init, start, draw_two, draw_four;
    card_t       top_card;
    logic        card_valid, card_ready;
    card_t       card;
    logic        play_valid, play_ready;
    play_req_t   play;
    logic        color_valid, color_ready;
    color_t      color;
    logic        out_valid, out_ready;
    card_t       out_card;
    logic        play_reject, turn_done;
    hand_cnt_t   hand_num;
    score_t      score;

    card_t       hand [$];  // reference hand, arrival order
    card_t       exp_out;
    logic [31:0] rng_state;
    int          errors = 0;
    int          checks = 0;
    int          dones_seen = 0;
    int          rejects_seen = 0;

    uno_player #(
        .PILE_DEPTH (25)
    ) dut (
        .i_clk (clk), .i_rst_n (rst_n),
        .i_init (init), .i_start (start), .i_draw_two (draw_two), .i_draw_four (draw_four),
        .i_top_card (top_card),
        .i_card_valid (card_valid), .i_card (card), .o_card_ready (card_ready),
        .i_play_valid (play_valid), .i_play (play), .o_play_ready (play_ready),
        .i_color_valid (color_valid), .i_color (color), .o_color_ready (color_ready),
        .o_out_valid (out_valid), .o_out_card (out_card), .i_out_ready (out_ready),
        .o_play_reject (play_reject), .o_turn_done (turn_done),
        .o_hand_num (hand_num), .o_score (score)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic card_t random_card();
        logic [31:0] r;
        r = xorshift32();
        return {r[9:8], 4'(r[7:0] % 15)};
    endfunction

    function automatic bit is_wild(card_t c);
        return c[3:0] >= 4'd13;
    endfunction

    // numbers score their rank, actions 20, wilds 50
    function automatic int card_points(card_t c);
        if (c[3:0] < 4'd10) return int'(c[3:0]);
        if (c[3:0] < 4'd13) return 20;
        return 50;
    endfunction

    function automatic int hand_score();
        int sum;
        sum = 0;
        foreach (hand[i]) sum += card_points(hand[i]);
        return sum;
    endfunction

    function automatic bit playable(card_t c, card_t top);
        return is_wild(c) || (c[5:4] == top[5:4]) || (c[3:0] == top[3:0]);
    endfunction

    // wilds match on rank only, the color is picked at play time
    function automatic int held_index(card_t c);
        foreach (hand[i]) begin
            if (is_wild(c) ? (hand[i][3:0] == c[3:0]) : (hand[i] == c)) return i;
        end
        return -1;
    endfunction

    function automatic card_t pick_number();
        int n;
        int first;
        n = hand.size();
        first = int'(xorshift32() % n);
        for (int i = 0; i < n; i++) begin
            if (!is_wild(hand[(first + i) % n])) return hand[(first + i) % n];
        end
        return EMPTY_CARD;
    endfunction

    function automatic card_t unheld_card(color_t col);
        for (int r = 0; r < 13; r++) begin
            if (held_index({col, 4'(r)}) < 0) return {col, 4'(r)};
        end
        return {col, 4'd12};
    endfunction

    task automatic check_value(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // compare at the negedge, where every DUT output is settled
    always @(negedge clk) begin
        if (out_valid && out_ready) begin
            check_value("out card", out_card, exp_out);
            check_value("score at out", score, hand_score());
            check_value("hand size at out", hand_num, hand.size());
        end
        if (play_reject) begin
            check_value("score at reject", score, hand_score());
            check_value("hand size at reject", hand_num, hand.size());
            rejects_seen++;
        end
        if (turn_done) begin
            check_value("score at turn end", score, hand_score());
            check_value("hand size at turn end", hand_num, hand.size());
            dones_seen++;
        end
    end

    task automatic begin_turn(input logic deal, input logic two, input logic four);
        init      = deal;
        start     = !deal;
        draw_two  = two;
        draw_four = four;
        @(posedge clk);
        #1;
        {init, start, draw_two, draw_four} = '0;
    endtask

    task automatic send_card(input card_t c);
        card_valid = 1'b1;
        card       = c;
        @(negedge clk);
        while (!card_ready) @(negedge clk);
        @(posedge clk);
        hand.push_back(c);
        #1;
        card_valid = 1'b0;
    endtask

    task automatic send_play(input logic pass, input card_t c);
        play_valid = 1'b1;
        play.pass  = pass;
        play.card  = c;
        @(negedge clk);
        while (!play_ready) @(negedge clk);
        @(posedge clk);
        #1;
        play_valid = 1'b0;
    endtask

    task automatic wait_outcome(input int d0, input int r0);
        while (dones_seen == d0 && rejects_seen == r0) @(posedge clk);
        #1;
    endtask

    task automatic hold_output(input int cycles);
        @(negedge clk);
        while (!out_valid) @(negedge clk);
        repeat (cycles) begin
            @(negedge clk);
            check_value("out valid while stalled", out_valid, 1);
            check_value("out card while stalled", out_card, exp_out);
        end
        @(posedge clk);
        #1;
        out_ready = 1'b1;
    endtask

    task automatic play_card(input card_t c, input color_t pick, input int stall);
        int d0, r0, s0, idx;
        bit reject;
        d0 = dones_seen;
        r0 = rejects_seen;
        s0 = score;
        idx = held_index(c);
        reject = !playable(c, top_card) || (idx < 0);
        out_ready = (stall == 0);
        send_play(1'b0, c);
        if (!reject) begin
            exp_out = is_wild(c) ? {pick, c[3:0]} : c;
            hand.delete(idx);
            if (is_wild(c)) begin
                check_value("color ready after wild request", color_ready, 1);
                color_valid = 1'b1;
                color       = pick;
                @(negedge clk);
                while (!color_ready) @(negedge clk);
                @(posedge clk);
                #1;
                color_valid = 1'b0;
            end
            if (stall > 0) hold_output(stall);
        end
        wait_outcome(d0, r0);
        out_ready = 1'b1;
        check_value("turn end pulses", dones_seen - d0, reject ? 0 : 1);
        check_value("reject pulses", rejects_seen - r0, reject ? 1 : 0);
        check_value("score drop", s0 - int'(score), reject ? 0 : card_points(c));
    endtask

    task automatic pass_turn(input card_t c);
        int d0, h0;
        d0 = dones_seen;
        h0 = hand.size();
        send_play(1'b1, '0);
        send_card(c);
        wait_outcome(d0, rejects_seen);
        check_value("turn end after pass", dones_seen - d0, 1);
        check_value("hand size after pass", hand_num, h0 + 1);
    endtask

    task automatic penalty_turn(input logic four);
        int n;
        n = four ? 4 : 2;
        begin_turn(1'b0, !four, four);
        for (int i = 0; i < n; i++) begin
            check_value("play ready during penalty", play_ready, 0);
            send_card(random_card());
        end
        @(negedge clk);
        check_value("card ready after penalty", card_ready, 0);
        check_value("play ready after penalty", play_ready, 1);
        check_value("hand size after penalty", hand_num, hand.size());
        @(posedge clk);
        #1;
        pass_turn(random_card());
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %-8s %s", name, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    initial begin
        card_t c;
        int    e0;
        int    d0;
        rst_n = 1'b0;
        {init, start, draw_two, draw_four} = '0;
        {card_valid, play_valid, color_valid} = '0;
        card = '0;
        play = '0;
        color = '0;
        top_card = 6'h05;  // red 5
        out_ready = 1'b1;
        rng_state = 32'h02e7_556e;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        e0 = errors;
        @(posedge clk);
        #1;
        check_value("valid and ready after reset",
                    {card_ready, play_ready, color_ready, out_valid}, 0);
        check_value("pulses after reset", {play_reject, turn_done}, 0);
        check_value("hand size after reset", hand_num, 0);
        check_value("score after reset", score, 0);
        report_test("reset", e0);

        e0 = errors;
        d0 = dones_seen;
        begin_turn(1'b1, 1'b0, 1'b0);
        repeat (DEAL_COUNT) send_card(random_card());
        wait_outcome(d0, rejects_seen);
        repeat (3) @(posedge clk);
        #1;
        check_value("turn end pulses after deal", dones_seen - d0, 1);
        check_value("hand size after deal", hand_num, DEAL_COUNT);
        check_value("score after deal", score, hand_score());
        report_test("deal", e0);

        e0 = errors;
        for (int i = 0; i < 2; i++) begin
            c = random_card();
            if (is_wild(c)) c[3:0] = c[3:0] - 4'd5;
            begin_turn(1'b0, 1'b0, 1'b0);
            pass_turn(c);
            c = pick_number();
            // same color first, then same rank in another color
            top_card = (i == 0) ? {c[5:4], 4'd11} : {color_t'(c[5:4] + 2'd1), c[3:0]};
            begin_turn(1'b0, 1'b0, 1'b0);
            play_card(c, 2'd0, (i == 0) ? 3 : 0);
        end
        report_test("play", e0);

        e0 = errors;
        top_card = 6'h05;
        begin_turn(1'b0, 1'b0, 1'b0);
        play_card(6'h23, 2'd0, 0);  // green 3 on red 5
        play_card(unheld_card(2'd0), 2'd0, 0);
        pass_turn(random_card());
        report_test("reject", e0);

        e0 = errors;
        begin_turn(1'b0, 1'b0, 1'b0);
        pass_turn(6'h2d);
        while (held_index(6'h0d) >= 0) begin
            begin_turn(1'b0, 1'b0, 1'b0);
            play_card(6'h0d, color_t'(xorshift32()), 2);
        end
        begin_turn(1'b0, 1'b0, 1'b0);
        pass_turn(6'h3e);
        begin_turn(1'b0, 1'b0, 1'b0);
        play_card(6'h1e, 2'd3, 0);
        begin_turn(1'b0, 1'b0, 1'b0);
        play_card(6'h0d, 2'd1, 0);  // none held now
        pass_turn(random_card());
        report_test("wild", e0);

        e0 = errors;
        penalty_turn(1'b0);
        penalty_turn(1'b1);
        report_test("penalty", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        repeat (N_STEPS * 200) @(posedge clk);
        $display("Timeout after %0d cycles, the DUT stopped answering", N_STEPS * 200);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: compile.f
rtl/uno_pkg.sv
rtl/card_decode.sv
rtl/color_pile.sv
rtl/turn_control.sv
rtl/hand_tally.sv
rtl/uno_player.sv
sim/uno_player_assertions.sv
sim/tb_uno_player.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_uno_player
FILELIST  := compile.f
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only --timing --assert -Wall
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
